//--- common/div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int WORD_W   = 32;
    localparam int SIGN_BIT = WORD_W;   // top bit of a mag_t field carries a sign flag between stages

    typedef logic [WORD_W-1:0] word_t;
    // the low 32 bits hold the magnitude, 2**31 included
    // on operations the top bit is the operand sign
    // on results it marks a value to negate
    typedef logic [WORD_W:0]   mag_t;
    typedef logic [5:0]        bitidx_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        LOOP,
        DONE
    } iter_state_t;

    localparam word_t DIV_ZERO_QUOT = '1;

endpackage

`default_nettype wire

//--- common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [2:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    localparam wb_adr_t ADR_DIVIDEND = 3'd0;
    localparam wb_adr_t ADR_DIVISOR  = 3'd1;
    localparam wb_adr_t ADR_CTRL     = 3'd2;
    localparam wb_adr_t ADR_STATUS   = 3'd3;
    localparam wb_adr_t ADR_QUOT     = 3'd4;
    localparam wb_adr_t ADR_REM      = 3'd5;

    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_SIGNED_BIT = 1;

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;
    localparam int STAT_DZ_BIT   = 2;

endpackage

`default_nettype wire

//--- common/div_if.sv
`timescale 1ns/1ps
`default_nettype none

interface div_op_if;

    logic              valid;
    logic              ready;
    div_pkg::mag_t     dividend;
    div_pkg::mag_t     divisor;
    logic              is_signed;
    div_pkg::bitidx_t  lead;        // leading one of the dividend magnitude, set by prep

    modport src (output valid, dividend, divisor, is_signed, lead, input ready);
    modport dst (input valid, dividend, divisor, is_signed, lead, output ready);

endinterface

interface div_res_if;

    logic              valid;       // one-cycle pulse, no ready
    div_pkg::mag_t     quotient;
    div_pkg::mag_t     remainder;
    logic              div_zero;

    modport src (output valid, quotient, remainder, div_zero);
    modport dst (input valid, quotient, remainder, div_zero);

endinterface

`default_nettype wire

//--- verilog/wb_div_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_div_slave (
    input  logic             clock_i,
    input  logic             nreset_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  wb_pkg::wb_adr_t  wb_adr_i,
    input  wb_pkg::wb_dat_t  wb_dat_i,
    output wb_pkg::wb_dat_t  wb_dat_o,
    output logic             wb_ack_o,
    div_op_if.src            op_o,
    div_res_if.dst           res_i
);

    logic             access;
    logic             start;
    logic             op_valid;
    logic             busy;
    logic             done;
    logic             div_zero;
    logic             is_signed;
    wb_pkg::wb_dat_t  dividend;
    wb_pkg::wb_dat_t  divisor;
    wb_pkg::wb_dat_t  quot;
    wb_pkg::wb_dat_t  rem;
    wb_pkg::wb_dat_t  rd_data;

    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;  // ack low keeps one ack per strobe
    assign start  = access && wb_we_i && (wb_adr_i == wb_pkg::ADR_CTRL)
                    && wb_dat_i[wb_pkg::CTRL_START_BIT] && !busy;

    always_ff @(posedge clock_i or negedge nreset_i) begin
        if (!nreset_i) begin
            wb_ack_o  <= 1'b0;
            op_valid  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            div_zero  <= 1'b0;
            is_signed <= 1'b0;
        end else begin
            wb_ack_o <= access;
            if (start) begin
                op_valid  <= 1'b1;
                busy      <= 1'b1;
                done      <= 1'b0;
                div_zero  <= 1'b0;
                is_signed <= wb_dat_i[wb_pkg::CTRL_SIGNED_BIT];
            end else if (op_valid && op_o.ready) begin
                op_valid <= 1'b0;
            end
            if (res_i.valid) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                div_zero <= res_i.div_zero;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (access && wb_we_i && (wb_adr_i == wb_pkg::ADR_DIVIDEND)) begin
            dividend <= wb_dat_i;
        end
        if (access && wb_we_i && (wb_adr_i == wb_pkg::ADR_DIVISOR)) begin
            divisor <= wb_dat_i;
        end
        if (res_i.valid) begin
            quot <= res_i.quotient[div_pkg::WORD_W-1:0];
            rem  <= res_i.remainder[div_pkg::WORD_W-1:0];
        end
        if (access) begin
            wb_dat_o <= rd_data;    // read data rides with the ack
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            wb_pkg::ADR_DIVIDEND: rd_data = dividend;
            wb_pkg::ADR_DIVISOR:  rd_data = divisor;
            wb_pkg::ADR_CTRL:     rd_data[wb_pkg::CTRL_SIGNED_BIT] = is_signed;
            wb_pkg::ADR_STATUS: begin
                rd_data[wb_pkg::STAT_BUSY_BIT] = busy;
                rd_data[wb_pkg::STAT_DONE_BIT] = done;
                rd_data[wb_pkg::STAT_DZ_BIT]   = div_zero;
            end
            wb_pkg::ADR_QUOT:     rd_data = quot;
            wb_pkg::ADR_REM:      rd_data = rem;
            default:              rd_data = '0;
        endcase
    end

    assign op_o.valid     = op_valid;
    assign op_o.dividend  = {1'b0, dividend};
    assign op_o.divisor   = {1'b0, divisor};
    assign op_o.is_signed = is_signed;
    assign op_o.lead      = '0;     // found later by prep

endmodule

`default_nettype wire

//--- divider/div_prep.sv
`timescale 1ns/1ps
`default_nettype none

module div_prep (
    input  logic   clock_i,
    input  logic   nreset_i,
    div_op_if.dst  op_i,
    div_op_if.src  op_o
);

    div_pkg::word_t    dvd_raw;
    div_pkg::word_t    dvs_raw;
    div_pkg::word_t    dvd_mag;
    div_pkg::word_t    dvs_mag;
    logic              dvd_neg;
    logic              dvs_neg;
    div_pkg::bitidx_t  lead;
    logic              out_valid;
    logic              take;

    assign dvd_raw = op_i.dividend[div_pkg::WORD_W-1:0];
    assign dvs_raw = op_i.divisor[div_pkg::WORD_W-1:0];

    // unsigned mode keeps the raw values and clears both signs
    assign dvd_neg = op_i.is_signed && dvd_raw[div_pkg::WORD_W-1];
    assign dvs_neg = op_i.is_signed && dvs_raw[div_pkg::WORD_W-1];
    assign dvd_mag = dvd_neg ? -dvd_raw : dvd_raw;
    assign dvs_mag = dvs_neg ? -dvs_raw : dvs_raw;

    always_comb begin
        lead = '0;
        for (int i = 0; i < div_pkg::WORD_W; i++) begin
            if (dvd_mag[i]) begin
                lead = div_pkg::bitidx_t'(i);   // highest set bit wins
            end
        end
    end

    assign op_i.ready = !out_valid || op_o.ready;
    assign take       = op_i.valid && op_i.ready;

    always_ff @(posedge clock_i or negedge nreset_i) begin
        if (!nreset_i) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (op_o.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (take) begin
            op_o.dividend  <= {dvd_neg, dvd_mag};
            op_o.divisor   <= {dvs_neg, dvs_mag};
            op_o.is_signed <= op_i.is_signed;
            op_o.lead      <= lead;
        end
    end

    assign op_o.valid = out_valid;

endmodule

`default_nettype wire

//--- divider/div_iter.sv
`timescale 1ns/1ps
`default_nettype none

module div_iter (
    input  logic    clock_i,
    input  logic    nreset_i,
    div_op_if.dst   op_i,
    div_res_if.src  res_o
);

    div_pkg::iter_state_t  state;
    div_pkg::bitidx_t      idx;
    div_pkg::word_t        dvd;
    div_pkg::word_t        dvs;
    div_pkg::word_t        prem;
    div_pkg::word_t        quot;
    logic                  dvd_neg;
    logic                  dvs_neg;
    logic                  dz;
    div_pkg::mag_t         shifted;
    div_pkg::mag_t         trial;

    // partial remainder stays below the divisor, so bit 32 of the trial is its sign
    assign shifted = {prem, dvd[idx[4:0]]};
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clock_i or negedge nreset_i) begin
        if (!nreset_i) begin
            state <= div_pkg::IDLE;
            idx   <= '0;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (op_i.valid) begin
                        state <= div_pkg::LOAD;
                        idx   <= op_i.lead;
                    end
                end
                div_pkg::LOAD: begin
                    state <= div_pkg::LOOP;
                    if (dvs == '0) begin
                        idx <= '0;      // divide by zero runs a single pass
                    end
                end
                div_pkg::LOOP: begin
                    if (idx == '0) begin
                        state <= div_pkg::DONE;
                    end else begin
                        idx <= idx - 1'b1;
                    end
                end
                default: state <= div_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (state == div_pkg::IDLE && op_i.valid) begin
            dvd     <= op_i.dividend[div_pkg::WORD_W-1:0];
            dvs     <= op_i.divisor[div_pkg::WORD_W-1:0];
            dvd_neg <= op_i.dividend[div_pkg::SIGN_BIT];
            dvs_neg <= op_i.divisor[div_pkg::SIGN_BIT];
        end
        if (state == div_pkg::LOAD) begin
            prem <= '0;
            quot <= '0;
            dz   <= (dvs == '0);
        end
        if (state == div_pkg::LOOP) begin
            if (!trial[div_pkg::SIGN_BIT]) begin
                prem <= trial[div_pkg::WORD_W-1:0];
                quot <= {quot[div_pkg::WORD_W-2:0], 1'b1};
            end else begin
                prem <= shifted[div_pkg::WORD_W-1:0];  // restore
                quot <= {quot[div_pkg::WORD_W-2:0], 1'b0};
            end
        end
    end

    assign op_i.ready      = (state == div_pkg::IDLE);
    assign res_o.valid     = (state == div_pkg::DONE);
    assign res_o.quotient  = {dvd_neg ^ dvs_neg, quot};
    assign res_o.remainder = {dvd_neg, dz ? dvd : prem};
    assign res_o.div_zero  = dz;

endmodule

`default_nettype wire

//--- divider/div_fix.sv
`timescale 1ns/1ps
`default_nettype none

module div_fix (
    input  logic    clock_i,
    input  logic    nreset_i,
    div_res_if.dst  res_i,
    div_res_if.src  res_o
);

    div_pkg::word_t  q_mag;
    div_pkg::word_t  r_mag;
    div_pkg::word_t  q_fixed;
    div_pkg::word_t  r_fixed;
    logic            out_valid;

    assign q_mag = res_i.quotient[div_pkg::WORD_W-1:0];
    assign r_mag = res_i.remainder[div_pkg::WORD_W-1:0];

    // the most negative value over minus one gives magnitude 2**31 with a positive sign,
    // which is already the wrapped quotient 32'h8000_0000 with remainder 0
    always_comb begin
        q_fixed = res_i.quotient[div_pkg::SIGN_BIT] ? -q_mag : q_mag;
        r_fixed = res_i.remainder[div_pkg::SIGN_BIT] ? -r_mag : r_mag;
        if (res_i.div_zero) begin
            q_fixed = div_pkg::DIV_ZERO_QUOT;
        end
    end

    always_ff @(posedge clock_i or negedge nreset_i) begin
        if (!nreset_i) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res_i.valid;
        end
    end

    always_ff @(posedge clock_i) begin
        if (res_i.valid) begin
            res_o.quotient  <= {1'b0, q_fixed};
            res_o.remainder <= {1'b0, r_fixed};
            res_o.div_zero  <= res_i.div_zero;
        end
    end

    assign res_o.valid = out_valid;

endmodule

`default_nettype wire

//--- verilog/div_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_top (
    input  logic             clock,
    input  logic             nreset,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  wb_pkg::wb_adr_t  wb_adr_i,
    input  wb_pkg::wb_dat_t  wb_dat_i,
    output wb_pkg::wb_dat_t  wb_dat_o,
    output logic             wb_ack_o
);

    div_op_if   op_req ();      // raw operands from the bus
    div_op_if   op_mag ();      // magnitudes, signs and leading one
    div_res_if  res_raw ();
    div_res_if  res_fix ();

    wb_div_slave u_slave (
        .clock_i  (clock),
        .nreset_i (nreset),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .op_o     (op_req.src),
        .res_i    (res_fix.dst)
    );

    div_prep u_prep (
        .clock_i  (clock),
        .nreset_i (nreset),
        .op_i     (op_req.dst),
        .op_o     (op_mag.src)
    );

    div_iter u_iter (
        .clock_i  (clock),
        .nreset_i (nreset),
        .op_i     (op_mag.dst),
        .res_o    (res_raw.src)
    );

    div_fix u_fix (
        .clock_i  (clock),
        .nreset_i (nreset),
        .res_i    (res_raw.dst),
        .res_o    (res_fix.src)
    );

endmodule

`default_nettype wire

//--- verif/div_chk.sv
`timescale 1ns/1ps
`default_nettype none

module div_chk (
    input logic clock_i,
    input logic nreset_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic busy_i,
    input logic done_i,
    input logic op_valid_i,
    input logic op_ready_i
);

    ack_one_cycle: assert property (@(posedge clock_i) disable iff (!nreset_i)
        ack_i |=> !ack_i)
        else $error("ack stayed high for more than one cycle");

    ack_after_strobe: assert property (@(posedge clock_i) disable iff (!nreset_i)
        $rose(ack_i) |-> $past(cyc_i && stb_i))
        else $error("ack rose without a strobe in the cycle before");

    busy_done_exclusive: assert property (@(posedge clock_i) disable iff (!nreset_i)
        !(busy_i && done_i))
        else $error("busy and done are both set");

    // held while ready is low, dropped right after the transfer
    op_valid_held: assert property (@(posedge clock_i) disable iff (!nreset_i)
        op_valid_i |=> (op_valid_i == !$past(op_ready_i)))
        else $error("operation valid did not follow the ready handshake");

endmodule

bind wb_div_slave div_chk u_chk (
    .clock_i    (clock_i),
    .nreset_i   (nreset_i),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .ack_i      (wb_ack_o),
    .busy_i     (busy),
    .done_i     (done),
    .op_valid_i (op_valid),
    .op_ready_i (op_o.ready)
);

`default_nettype wire

//--- verif/div_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_tb;

    localparam int ACK_TIMEOUT = 16;
    localparam int DONE_POLLS  = 40;

    logic             clock;
    logic             nreset;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    wb_pkg::wb_adr_t  wb_adr;
    wb_pkg::wb_dat_t  wb_dat_w;
    wb_pkg::wb_dat_t  wb_dat_r;
    logic             wb_ack;

    logic [31:0]      lfsr;
    int               checks;
    int               errors;
    int               timeouts;
    int               accesses;
    int               ack_seen;

    div_top DUT (
        .clock    (clock),
        .nreset   (nreset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (wb_ack) begin
            ack_seen <= ack_seen + 1;
        end
    end

    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // quotient and remainder straight from the divider's rules
    function automatic void ref_divide(input logic [31:0] a, input logic [31:0] b,
                                       input logic sgn, output logic [31:0] q,
                                       output logic [31:0] r);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = 32'h8000_0000;
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);    // truncates toward zero
            r = $signed(a) % $signed(b);    // sign follows the dividend
        end else begin
            q = a / b;
            r = a % b;
        end
    endfunction

    function automatic wb_pkg::wb_dat_t ctrl_word(input logic sgn);
        wb_pkg::wb_dat_t w;
        w = '0;
        w[wb_pkg::CTRL_START_BIT]  = 1'b1;
        w[wb_pkg::CTRL_SIGNED_BIT] = sgn;
        return w;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_access(input logic we, input wb_pkg::wb_adr_t adr,
                              input wb_pkg::wb_dat_t wdat, output wb_pkg::wb_dat_t rdat);
        logic got;
        got  = 1'b0;
        rdat = '0;
        if (timeouts == 0) begin
            @(posedge clock);
            wb_cyc   <= 1'b1;
            wb_stb   <= 1'b1;
            wb_we    <= we;
            wb_adr   <= adr;
            wb_dat_w <= wdat;
            accesses++;
            for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
                @(posedge clock);
                got = wb_ack;
            end
            if (got) begin
                rdat = wb_dat_r;
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
                @(posedge clock);
                check_word({31'b0, wb_ack}, 32'd0, "ack one cycle after it was seen");
            end else begin
                timeouts++;
                $display("timeout: no ack for the access to address %0d", adr);
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
            end
        end
    endtask

    task automatic bus_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat);
        wb_pkg::wb_dat_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic wait_done(output wb_pkg::wb_dat_t status);
        logic fin;
        fin    = 1'b0;
        status = '0;
        for (int n = 0; n < DONE_POLLS && !fin && timeouts == 0; n++) begin
            bus_read(wb_pkg::ADR_STATUS, status);
            fin = status[wb_pkg::STAT_DONE_BIT];
        end
        if (!fin && timeouts == 0) begin
            timeouts++;
            $display("timeout: the done bit never came up");
        end
    endtask

    task automatic check_result(input logic [31:0] a, input logic [31:0] b, input logic sgn);
        wb_pkg::wb_dat_t st;
        wb_pkg::wb_dat_t q;
        wb_pkg::wb_dat_t r;
        logic [31:0]     exp_q;
        logic [31:0]     exp_r;
        string           tag;
        ref_divide(a, b, sgn, exp_q, exp_r);
        tag = $sformatf("%s %h / %h", sgn ? "signed" : "unsigned", a, b);
        wait_done(st);
        check_word({31'b0, st[wb_pkg::STAT_DZ_BIT]}, {31'b0, b == '0}, {tag, " dz flag"});
        check_word({31'b0, st[wb_pkg::STAT_BUSY_BIT]}, 32'd0, {tag, " busy at done"});
        bus_read(wb_pkg::ADR_QUOT, q);
        check_word(q, exp_q, {tag, " quotient"});
        bus_read(wb_pkg::ADR_REM, r);
        check_word(r, exp_r, {tag, " remainder"});
    endtask

    task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic sgn);
        bus_write(wb_pkg::ADR_DIVIDEND, a);
        bus_write(wb_pkg::ADR_DIVISOR, b);
        bus_write(wb_pkg::ADR_CTRL, ctrl_word(sgn));
        check_result(a, b, sgn);
    endtask

    initial begin
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     sh;
        logic [31:0]     exp_q;
        logic [31:0]     exp_r;
        wb_pkg::wb_dat_t rd;
        clock    = 1'b0;
        nreset   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        lfsr     = 32'h311c;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        accesses = 0;
        ack_seen = 0;
        repeat (2) @(posedge clock);
        nreset <= 1'b1;

        draw_bits(32, a);
        draw_bits(32, b);
        bus_write(wb_pkg::ADR_DIVIDEND, a);
        bus_write(wb_pkg::ADR_DIVISOR, b);
        bus_read(wb_pkg::ADR_DIVIDEND, rd);
        check_word(rd, a, "dividend read-back");
        bus_read(wb_pkg::ADR_DIVISOR, rd);
        check_word(rd, b, "divisor read-back");
        bus_read(3'd6, rd);
        check_word(rd, '0, "unmapped address 6");
        bus_read(3'd7, rd);
        check_word(rd, '0, "unmapped address 7");

        for (int i = 0; i < 24; i++) begin
            draw_bits(32, a);
            draw_bits(5, sh);
            draw_bits(32, b);
            run_div(a, b >> sh, 1'b0);  // the shift spreads the divisor sizes
        end

        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < 6; i++) begin
                draw_bits(31, a);
                draw_bits(5, sh);
                draw_bits(31, b);
                b = b >> sh;
                run_div(c[0] ? -a : a, c[1] ? -b : b, 1'b1);
            end
        end

        run_div(32'h1234_5678, 32'd0, 1'b0);
        run_div(32'hfedc_ba98, 32'd0, 1'b1);
        run_div(32'd0, 32'd0, 1'b1);

        run_div(32'h8000_0000, 32'hffff_ffff, 1'b1);
        run_div(32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_div(32'd5, 32'd9, 1'b0);
        run_div(-32'd5, 32'd9, 1'b1);
        run_div(32'd0, 32'd7, 1'b0);
        run_div(32'd0, -32'd7, 1'b1);
        run_div(32'd123457, 32'd123457, 1'b0);
        run_div(-32'd77, -32'd77, 1'b1);

        // a long first operation, then a second start while it runs
        a = 32'hf000_0001;
        b = 32'd3;
        bus_write(wb_pkg::ADR_DIVIDEND, a);
        bus_write(wb_pkg::ADR_DIVISOR, b);
        bus_write(wb_pkg::ADR_CTRL, ctrl_word(1'b0));
        bus_read(wb_pkg::ADR_STATUS, rd);
        check_word({31'b0, rd[wb_pkg::STAT_BUSY_BIT]}, 32'd1, "busy after start");
        check_word({31'b0, rd[wb_pkg::STAT_DONE_BIT]}, 32'd0, "done after start");
        bus_write(wb_pkg::ADR_DIVISOR, 32'd7);
        bus_write(wb_pkg::ADR_CTRL, ctrl_word(1'b1));
        check_result(a, b, 1'b0);
        bus_read(wb_pkg::ADR_STATUS, rd);
        check_word({31'b0, rd[wb_pkg::STAT_DONE_BIT]}, 32'd1, "done held after completion");
        ref_divide(a, b, 1'b0, exp_q, exp_r);
        for (int n = 0; n < DONE_POLLS && timeouts == 0; n++) begin
            bus_read(wb_pkg::ADR_QUOT, rd);     // outlasts a second operation, had it started
            check_word(rd, exp_q, "quotient kept after the ignored start");
        end

        repeat (2) @(posedge clock);
        check_word(32'(ack_seen), 32'(accesses), "ack count against access count");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
common/div_pkg.sv
common/wb_pkg.sv
common/div_if.sv
verilog/wb_div_slave.sv
divider/div_prep.sv
divider/div_iter.sv
divider/div_fix.sv
verilog/div_top.sv
verif/div_chk.sv
verif/div_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the divider testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module div_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vdiv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" <<< "$out"; then
    exit 0
fi
exit 1
